// File: verification/rv_exec_golden.txt
// inst_pc_rd_rfwen_data_memop_memaddr_storedata_taken_target_ecall_illegal
// mem_op codes: 0 none, 2 lbu, 5 lw, 6 sb, 8 sw
00500093_00000000_01_1_00000005_0_00000000_00000000_0_00000000_0_0 // addi x1,x0,5
ffd00113_00000004_02_1_fffffffd_0_00000000_00000000_0_00000000_0_0 // addi x2,x0,-3
123451b7_00000008_03_1_12345000_0_00000000_00000000_0_00000000_0_0 // lui x3
00001217_0000000c_04_1_0000100c_0_00000000_00000000_0_00000000_0_0 // auipc x4
00700013_00000010_00_0_00000007_0_00000000_00000000_0_00000000_0_0 // addi x0,x0,7
002082b3_00000014_05_1_00000002_0_00000000_00000000_0_00000000_0_0 // add x5,x1,x2
40128333_00000018_06_1_fffffffd_0_00000000_00000000_0_00000000_0_0 // sub x6,x5,x1
0021f3b3_0000001c_07_1_12345000_0_00000000_00000000_0_00000000_0_0 // and x7,x3,x2
0013e433_00000020_08_1_12345005_0_00000000_00000000_0_00000000_0_0 // or x8,x7,x1
002444b3_00000024_09_1_edcbaff8_0_00000000_00000000_0_00000000_0_0 // xor x9,x8,x2
00109533_00000028_0a_1_000000a0_0_00000000_00000000_0_00000000_0_0 // sll x10,x1,x1
401155b3_0000002c_0b_1_ffffffff_0_00000000_00000000_0_00000000_0_0 // sra x11,x2,x1
00115633_00000030_0c_1_07ffffff_0_00000000_00000000_0_00000000_0_0 // srl x12,x2,x1
001126b3_00000034_0d_1_00000001_0_00000000_00000000_0_00000000_0_0 // slt x13,x2,x1
00113733_00000038_0e_1_00000000_0_00000000_00000000_0_00000000_0_0 // sltu x14,x2,x1
0080a423_0000003c_08_0_00000000_8_0000000d_12345005_0_00000000_0_0 // sw x8,8(x1)
ffc1a783_00000040_0f_0_00000000_5_12344ffc_00000000_0_00000000_0_0 // lw x15,-4(x3)
0010c803_00000044_10_0_00000000_2_00000006_00000000_0_00000000_0_0 // lbu x16,1(x1)
00200023_00000048_00_0_00000000_6_00000000_fffffffd_0_00000000_0_0 // sb x2,0(x0)
00108863_0000004c_10_0_00000000_0_00000000_00000000_1_0000005c_0_0 // beq x1,x1,+16
fe20cce3_00000050_19_0_00000000_0_00000000_00000000_0_00000048_0_0 // blt x1,x2,-8
fe20ece3_00000054_19_0_00000000_0_00000000_00000000_1_0000004c_0_0 // bltu x1,x2,-8
020008ef_00000058_11_1_0000005c_0_00000000_00000000_1_00000078_0_0 // jal x17,+32
00388967_0000005c_12_1_00000060_0_00000000_00000000_1_0000005e_0_0 // jalr x18,3(x17)
012069b3_00000060_13_1_00000060_0_00000000_00000000_0_00000000_0_0 // or x19,x0,x18
00000073_00000064_00_0_00000000_0_00000000_00000000_0_00000000_1_0 // ecall
300110f3_00000068_01_0_00000000_0_00000000_00000000_0_00000000_0_1 // csrrw x1,mstatus,x2
ffffffff_0000006c_1f_0_00000000_0_00000000_00000000_0_00000000_0_1 // undefined word
00008a13_00000070_14_1_00000005_0_00000000_00000000_0_00000000_0_0 // addi x20,x1,0

// File: verilog.f
source/rv_core_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_exec_core.sv
verification/tb_rv_exec_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_exec_core -Mdir obj_dir -f verilog.f

./obj_dir/Vtb_rv_exec_core

// File: verification/tb_rv_exec_core.sv
`timescale 1ns/1ps

module tb_rv_exec_core;

    localparam int NUM_ENTRIES = 29;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ENTRIES + 50;
    localparam int ENTRY_W = 220;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_ready;
    logic [31:0]          in_inst;
    logic [31:0]          in_pc;
    logic                 res_valid;
    logic                 res_ready;
    logic [31:0]          res_pc;
    logic [4:0]           res_rd;
    logic                 res_rf_wen;
    logic [31:0]          res_data;
    rv_core_pkg::mem_op_e res_mem_op;
    logic [31:0]          res_mem_addr;
    logic [31:0]          res_store_data;
    logic                 res_branch_taken;
    logic [31:0]          res_target;
    logic                 res_ecall;
    logic                 res_illegal;

    // inst, pc, rd, rf_wen, data, mem_op, mem_addr, store_data, taken, target, ecall, illegal
    logic [ENTRY_W-1:0] golden [NUM_ENTRIES];
    int                 checked;

    rv_exec_core rv_exec_core_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_inst          (in_inst),
        .in_pc            (in_pc),
        .res_valid        (res_valid),
        .res_ready        (res_ready),
        .res_pc           (res_pc),
        .res_rd           (res_rd),
        .res_rf_wen       (res_rf_wen),
        .res_data         (res_data),
        .res_mem_op       (res_mem_op),
        .res_mem_addr     (res_mem_addr),
        .res_store_data   (res_store_data),
        .res_branch_taken (res_branch_taken),
        .res_target       (res_target),
        .res_ecall        (res_ecall),
        .res_illegal      (res_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_result(input int idx);
        logic [ENTRY_W-1:0] e;
        e = golden[idx];
        compare_field("res_pc", e[187:156], res_pc);
        compare_field("res_rd", {24'd0, e[155:148]}, {27'd0, res_rd});
        compare_field("res_rf_wen", {28'd0, e[147:144]}, {31'd0, res_rf_wen});
        compare_field("res_data", e[143:112], res_data);
        compare_field("res_mem_op", {28'd0, e[111:108]}, {28'd0, res_mem_op});
        compare_field("res_mem_addr", e[107:76], res_mem_addr);
        compare_field("res_store_data", e[75:44], res_store_data);
        compare_field("res_branch_taken", {28'd0, e[43:40]}, {31'd0, res_branch_taken});
        compare_field("res_target", e[39:8], res_target);
        compare_field("res_ecall", {28'd0, e[7:4]}, {31'd0, res_ecall});
        compare_field("res_illegal", {28'd0, e[3:0]}, {31'd0, res_illegal});
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        res_ready = 1'b0;
        $readmemh("verification/rv_exec_golden.txt", golden);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            assert (!$isunknown(golden[i]) && golden[i][219:188] != '0) else begin
                abort_run($sformatf("golden entry %0d is missing from the data file", i));
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    // next instruction only after a transfer
    initial begin : source
        int   idx;
        logic fire;
        idx = 0;
        fire = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        compare_field("in_ready", 32'd1, {31'd0, in_ready});
        compare_field("res_valid", 32'd0, {31'd0, res_valid});
        @(posedge clk);
        while (idx < NUM_ENTRIES) begin
            in_valid <= 1'b1;
            in_inst <= golden[idx][219:188];
            in_pc <= golden[idx][187:156];
            @(negedge clk);
            fire = in_valid && in_ready;  // sampled mid-cycle
            @(posedge clk);
            if (fire) idx++;
        end
        in_valid <= 1'b0;
    end

    // random back-pressure sink checking in golden order
    initial begin : sink
        logic extra;
        void'($urandom(32'h45a40fc8));
        checked = 0;
        extra = 1'b0;
        @(posedge rst_n);
        while (checked < NUM_ENTRIES) begin
            @(posedge clk);
            res_ready <= (($urandom % 4) != 0);
            @(negedge clk);
            if (res_valid && res_ready) begin
                check_result(checked);
                checked++;
            end
        end
        repeat (8) begin
            @(negedge clk);
            if (res_valid) extra = 1'b1;  // duplicate or stray result
        end
        if (extra) begin
            abort_run("a result appeared after the last golden entry was matched");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("timeout: only %0d of %0d results arrived", checked, NUM_ENTRIES));
    end

endmodule

// File: source/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [31:0]          in_inst,
    input  logic [31:0]          in_pc,
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic [31:0]          res_pc,
    output logic [4:0]           res_rd,
    output logic                 res_rf_wen,
    output logic [31:0]          res_data,
    output rv_core_pkg::mem_op_e res_mem_op,
    output logic [31:0]          res_mem_addr,
    output logic [31:0]          res_store_data,
    output logic                 res_branch_taken,
    output logic [31:0]          res_target,
    output logic                 res_ecall,
    output logic                 res_illegal
);

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        d_valid;
    logic        d_ready;
    logic [31:0] d_pc;
    logic [31:0] d_op1;
    logic [31:0] d_op2;
    logic [31:0] d_rs2_data;
    logic [31:0] d_branch_imm;
    logic [4:0]  d_rd;
    logic        d_ecall;
    logic        d_illegal;
    rv_core_pkg::alu_fun_e d_alu_fun;
    rv_core_pkg::mem_op_e  d_mem_op;
    rv_core_pkg::wb_sel_e  d_wb_sel;

    decode_stage decode_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .d_pc         (d_pc),
        .d_alu_fun    (d_alu_fun),
        .d_op1        (d_op1),
        .d_op2        (d_op2),
        .d_rs2_data   (d_rs2_data),
        .d_branch_imm (d_branch_imm),
        .d_rd         (d_rd),
        .d_mem_op     (d_mem_op),
        .d_wb_sel     (d_wb_sel),
        .d_ecall      (d_ecall),
        .d_illegal    (d_illegal)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    execute_stage execute_stage_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .d_valid          (d_valid),
        .d_ready          (d_ready),
        .d_pc             (d_pc),
        .d_alu_fun        (d_alu_fun),
        .d_op1            (d_op1),
        .d_op2            (d_op2),
        .d_rs2_data       (d_rs2_data),
        .d_branch_imm     (d_branch_imm),
        .d_rd             (d_rd),
        .d_mem_op         (d_mem_op),
        .d_wb_sel         (d_wb_sel),
        .d_ecall          (d_ecall),
        .d_illegal        (d_illegal),
        .wb_en            (wb_en),
        .wb_addr          (wb_addr),
        .wb_data          (wb_data),
        .res_valid        (res_valid),
        .res_ready        (res_ready),
        .res_pc           (res_pc),
        .res_rd           (res_rd),
        .res_rf_wen       (res_rf_wen),
        .res_data         (res_data),
        .res_mem_op       (res_mem_op),
        .res_mem_addr     (res_mem_addr),
        .res_store_data   (res_store_data),
        .res_branch_taken (res_branch_taken),
        .res_target       (res_target),
        .res_ecall        (res_ecall),
        .res_illegal      (res_illegal)
    );

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  d_valid,
    output logic                  d_ready,
    input  logic [31:0]           d_pc,
    input  rv_core_pkg::alu_fun_e d_alu_fun,
    input  logic [31:0]           d_op1,
    input  logic [31:0]           d_op2,
    input  logic [31:0]           d_rs2_data,
    input  logic [31:0]           d_branch_imm,
    input  logic [4:0]            d_rd,
    input  rv_core_pkg::mem_op_e  d_mem_op,
    input  rv_core_pkg::wb_sel_e  d_wb_sel,
    input  logic                  d_ecall,
    input  logic                  d_illegal,
    output logic                  wb_en,
    output logic [4:0]            wb_addr,
    output logic [31:0]           wb_data,
    output logic                  res_valid,
    input  logic                  res_ready,
    output logic [31:0]           res_pc,
    output logic [4:0]            res_rd,
    output logic                  res_rf_wen,
    output logic [31:0]           res_data,
    output rv_core_pkg::mem_op_e  res_mem_op,
    output logic [31:0]           res_mem_addr,
    output logic [31:0]           res_store_data,
    output logic                  res_branch_taken,
    output logic [31:0]           res_target,
    output logic                  res_ecall,
    output logic                  res_illegal
);

    logic        accept;
    logic [31:0] sum;
    logic [31:0] alu_out;
    logic        is_branch;
    logic        cmp_true;
    logic        is_jump;
    logic        is_store;
    logic        wb_used;
    logic [31:0] target;

    assign d_ready = !res_valid || res_ready;
    assign accept = d_valid && d_ready;
    assign sum = d_op1 + d_op2;  // also the memory address

    always_comb begin
        case (d_alu_fun)
            rv_core_pkg::ALU_ADD:  alu_out = sum;
            rv_core_pkg::ALU_SUB:  alu_out = d_op1 - d_op2;
            rv_core_pkg::ALU_AND:  alu_out = d_op1 & d_op2;
            rv_core_pkg::ALU_OR:   alu_out = d_op1 | d_op2;
            rv_core_pkg::ALU_XOR:  alu_out = d_op1 ^ d_op2;
            rv_core_pkg::ALU_SLL:  alu_out = d_op1 << d_op2[4:0];
            rv_core_pkg::ALU_SRL:  alu_out = d_op1 >> d_op2[4:0];
            rv_core_pkg::ALU_SRA:  alu_out = $unsigned($signed(d_op1) >>> d_op2[4:0]);
            rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(d_op1) < $signed(d_op2)};
            rv_core_pkg::ALU_SLTU: alu_out = {31'b0, d_op1 < d_op2};
            rv_core_pkg::ALU_JALR: alu_out = {sum[31:1], 1'b0};
            default:               alu_out = '0;
        endcase
    end

    always_comb begin
        is_branch = 1'b1;
        case (d_alu_fun)
            rv_core_pkg::BR_BEQ:  cmp_true = d_op1 == d_op2;
            rv_core_pkg::BR_BNE:  cmp_true = d_op1 != d_op2;
            rv_core_pkg::BR_BLT:  cmp_true = $signed(d_op1) < $signed(d_op2);
            rv_core_pkg::BR_BGE:  cmp_true = $signed(d_op1) >= $signed(d_op2);
            rv_core_pkg::BR_BLTU: cmp_true = d_op1 < d_op2;
            rv_core_pkg::BR_BGEU: cmp_true = d_op1 >= d_op2;
            default: begin
                is_branch = 1'b0;
                cmp_true = 1'b0;
            end
        endcase
    end

    assign is_jump = (d_wb_sel == rv_core_pkg::WB_PC4);
    assign is_store = d_mem_op inside {rv_core_pkg::MEM_SB, rv_core_pkg::MEM_SH, rv_core_pkg::MEM_SW};
    assign wb_used = (d_wb_sel == rv_core_pkg::WB_ALU) || is_jump;
    assign target = is_branch ? d_pc + d_branch_imm : (is_jump ? alu_out : '0);

    // register file write lands on the accept edge
    assign wb_en = accept && wb_used && d_rd != '0;
    assign wb_addr = d_rd;
    assign wb_data = is_jump ? d_pc + 32'd4 : alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_pc <= '0;
            res_rd <= '0;
            res_rf_wen <= 1'b0;
            res_data <= '0;
            res_mem_op <= rv_core_pkg::MEM_NONE;
            res_mem_addr <= '0;
            res_store_data <= '0;
            res_branch_taken <= 1'b0;
            res_target <= '0;
            res_ecall <= 1'b0;
            res_illegal <= 1'b0;
        end else if (accept) begin
            res_valid <= 1'b1;
            res_pc <= d_pc;
            res_rd <= d_rd;
            res_rf_wen <= wb_used && d_rd != '0;
            res_data <= wb_used ? wb_data : '0;
            res_mem_op <= d_mem_op;
            res_mem_addr <= (d_mem_op != rv_core_pkg::MEM_NONE) ? sum : '0;
            res_store_data <= is_store ? d_rs2_data : '0;
            res_branch_taken <= cmp_true || is_jump;
            res_target <= target;
            res_ecall <= d_ecall;
            res_illegal <= d_illegal;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_pc));

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_inst,
    input  logic [31:0]           in_pc,
    output logic [4:0]            rs1_addr,
    output logic [4:0]            rs2_addr,
    input  logic [31:0]           rs1_data,
    input  logic [31:0]           rs2_data,
    output logic                  d_valid,
    input  logic                  d_ready,
    output logic [31:0]           d_pc,
    output rv_core_pkg::alu_fun_e d_alu_fun,
    output logic [31:0]           d_op1,
    output logic [31:0]           d_op2,
    output logic [31:0]           d_rs2_data,
    output logic [31:0]           d_branch_imm,
    output logic [4:0]            d_rd,
    output rv_core_pkg::mem_op_e  d_mem_op,
    output rv_core_pkg::wb_sel_e  d_wb_sel,
    output logic                  d_ecall,
    output logic                  d_illegal
);

    rv_core_pkg::alu_fun_e alu_fun;
    rv_core_pkg::op1_sel_e op1_sel;
    rv_core_pkg::op2_sel_e op2_sel;
    rv_core_pkg::mem_op_e  mem_op;
    rv_core_pkg::wb_sel_e  wb_sel;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [4:0]  rd;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        ecall;
    logic        illegal;
    logic [31:0] op1;
    logic [31:0] op2;
    logic        hazard;

    inst_decoder inst_decoder_inst (
        .inst     (in_inst),
        .alu_fun  (alu_fun),
        .op1_sel  (op1_sel),
        .op2_sel  (op2_sel),
        .mem_op   (mem_op),
        .wb_sel   (wb_sel),
        .imm_i    (imm_i),
        .imm_s    (imm_s),
        .imm_b    (imm_b),
        .imm_j    (imm_j),
        .imm_u    (imm_u),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .rd       (rd),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .ecall    (ecall),
        .illegal  (illegal)
    );

    always_comb begin
        case (op1_sel)
            rv_core_pkg::OP1_RS1: op1 = rs1_data;
            rv_core_pkg::OP1_PC:  op1 = in_pc;
            default:              op1 = '0;
        endcase
        case (op2_sel)
            rv_core_pkg::OP2_RS2: op2 = rs2_data;
            rv_core_pkg::OP2_IMI: op2 = imm_i;
            rv_core_pkg::OP2_IMS: op2 = imm_s;
            rv_core_pkg::OP2_IMJ: op2 = imm_j;
            rv_core_pkg::OP2_IMU: op2 = imm_u;
            default:              op2 = '0;
        endcase
    end

    // rd in the decode register is not yet in the register file
    assign hazard = d_valid && d_rd != '0
                 && (d_wb_sel == rv_core_pkg::WB_ALU || d_wb_sel == rv_core_pkg::WB_PC4)
                 && ((uses_rs1 && rs1_addr == d_rd) || (uses_rs2 && rs2_addr == d_rd));
    assign in_ready = !hazard && (!d_valid || d_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            d_pc <= '0;
            d_alu_fun <= rv_core_pkg::ALU_NONE;
            d_op1 <= '0;
            d_op2 <= '0;
            d_rs2_data <= '0;
            d_branch_imm <= '0;
            d_rd <= '0;
            d_mem_op <= rv_core_pkg::MEM_NONE;
            d_wb_sel <= rv_core_pkg::WB_NONE;
            d_ecall <= 1'b0;
            d_illegal <= 1'b0;
        end else if (in_valid && in_ready) begin
            d_valid <= 1'b1;
            d_pc <= in_pc;
            d_alu_fun <= alu_fun;
            d_op1 <= op1;
            d_op2 <= op2;
            d_rs2_data <= rs2_data;  // store data
            d_branch_imm <= imm_b;
            d_rd <= rd;
            d_mem_op <= mem_op;
            d_wb_sel <= wb_sel;
            d_ecall <= ecall;
            d_illegal <= illegal;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    a_d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        d_valid && !d_ready |=> d_valid && $stable(d_pc) && $stable(d_op1)
            && $stable(d_op2) && $stable(d_rs2_data) && $stable(d_rd)
            && $stable(d_alu_fun) && $stable(d_mem_op) && $stable(d_wb_sel));

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input  logic                               wb_en,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       wb_data
);

    logic [rv_core_pkg::XLEN-1:0] regs [1:31];  // x0 not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // execute filters rd == 0 before it drives the port
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> wb_addr != '0);

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]           inst,
    output rv_core_pkg::alu_fun_e alu_fun,
    output rv_core_pkg::op1_sel_e op1_sel,
    output rv_core_pkg::op2_sel_e op2_sel,
    output rv_core_pkg::mem_op_e  mem_op,
    output rv_core_pkg::wb_sel_e  wb_sel,
    output logic [31:0]           imm_i,
    output logic [31:0]           imm_s,
    output logic [31:0]           imm_b,
    output logic [31:0]           imm_j,
    output logic [31:0]           imm_u,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic                  uses_rs1,
    output logic                  uses_rs2,
    output logic                  ecall,
    output logic                  illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        alu_fun = rv_core_pkg::ALU_NONE;
        op1_sel = rv_core_pkg::OP1_ZERO;
        op2_sel = rv_core_pkg::OP2_ZERO;
        mem_op = rv_core_pkg::MEM_NONE;
        wb_sel = rv_core_pkg::WB_NONE;
        ecall = 1'b0;
        illegal = 1'b1;  // cleared only on a match
        case (inst[6:0])
            rv_core_pkg::OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_fun = rv_core_pkg::ALU_ADD;
                    {7'h20, 3'b000}: alu_fun = rv_core_pkg::ALU_SUB;
                    {7'h00, 3'b001}: alu_fun = rv_core_pkg::ALU_SLL;
                    {7'h00, 3'b010}: alu_fun = rv_core_pkg::ALU_SLT;
                    {7'h00, 3'b011}: alu_fun = rv_core_pkg::ALU_SLTU;
                    {7'h00, 3'b100}: alu_fun = rv_core_pkg::ALU_XOR;
                    {7'h00, 3'b101}: alu_fun = rv_core_pkg::ALU_SRL;
                    {7'h20, 3'b101}: alu_fun = rv_core_pkg::ALU_SRA;
                    {7'h00, 3'b110}: alu_fun = rv_core_pkg::ALU_OR;
                    {7'h00, 3'b111}: alu_fun = rv_core_pkg::ALU_AND;
                    default: alu_fun = rv_core_pkg::ALU_NONE;
                endcase
                if (alu_fun != rv_core_pkg::ALU_NONE) begin
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_RS2;
                    wb_sel = rv_core_pkg::WB_ALU;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::OP_IMM: begin
                case (funct3)
                    3'b000: alu_fun = rv_core_pkg::ALU_ADD;
                    3'b010: alu_fun = rv_core_pkg::ALU_SLT;
                    3'b011: alu_fun = rv_core_pkg::ALU_SLTU;
                    3'b100: alu_fun = rv_core_pkg::ALU_XOR;
                    3'b110: alu_fun = rv_core_pkg::ALU_OR;
                    3'b111: alu_fun = rv_core_pkg::ALU_AND;
                    3'b001: if (funct7 == 7'h00) alu_fun = rv_core_pkg::ALU_SLL;
                    default: begin
                        if (funct7 == 7'h00) alu_fun = rv_core_pkg::ALU_SRL;
                        else if (funct7 == 7'h20) alu_fun = rv_core_pkg::ALU_SRA;
                    end
                endcase
                if (alu_fun != rv_core_pkg::ALU_NONE) begin
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_IMI;
                    wb_sel = rv_core_pkg::WB_ALU;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::LOAD: begin
                case (funct3)
                    3'b000: mem_op = rv_core_pkg::MEM_LB;
                    3'b001: mem_op = rv_core_pkg::MEM_LH;
                    3'b010: mem_op = rv_core_pkg::MEM_LW;
                    3'b100: mem_op = rv_core_pkg::MEM_LBU;
                    3'b101: mem_op = rv_core_pkg::MEM_LHU;
                    default: mem_op = rv_core_pkg::MEM_NONE;
                endcase
                if (mem_op != rv_core_pkg::MEM_NONE) begin
                    alu_fun = rv_core_pkg::ALU_ADD;
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_IMI;
                    wb_sel = rv_core_pkg::WB_MEM;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::STORE: begin
                case (funct3)
                    3'b000: mem_op = rv_core_pkg::MEM_SB;
                    3'b001: mem_op = rv_core_pkg::MEM_SH;
                    3'b010: mem_op = rv_core_pkg::MEM_SW;
                    default: mem_op = rv_core_pkg::MEM_NONE;
                endcase
                if (mem_op != rv_core_pkg::MEM_NONE) begin
                    alu_fun = rv_core_pkg::ALU_ADD;
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_IMS;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::BRANCH: begin
                case (funct3)
                    3'b000: alu_fun = rv_core_pkg::BR_BEQ;
                    3'b001: alu_fun = rv_core_pkg::BR_BNE;
                    3'b100: alu_fun = rv_core_pkg::BR_BLT;
                    3'b101: alu_fun = rv_core_pkg::BR_BGE;
                    3'b110: alu_fun = rv_core_pkg::BR_BLTU;
                    3'b111: alu_fun = rv_core_pkg::BR_BGEU;
                    default: alu_fun = rv_core_pkg::ALU_NONE;
                endcase
                if (alu_fun != rv_core_pkg::ALU_NONE) begin
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_RS2;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::JAL: begin
                alu_fun = rv_core_pkg::ALU_ADD;
                op1_sel = rv_core_pkg::OP1_PC;
                op2_sel = rv_core_pkg::OP2_IMJ;
                wb_sel = rv_core_pkg::WB_PC4;
                illegal = 1'b0;
            end
            rv_core_pkg::JALR: begin
                if (funct3 == 3'b000) begin
                    alu_fun = rv_core_pkg::ALU_JALR;
                    op1_sel = rv_core_pkg::OP1_RS1;
                    op2_sel = rv_core_pkg::OP2_IMI;
                    wb_sel = rv_core_pkg::WB_PC4;
                    illegal = 1'b0;
                end
            end
            rv_core_pkg::LUI, rv_core_pkg::AUIPC: begin
                alu_fun = rv_core_pkg::ALU_ADD;
                op1_sel = (inst[6:0] == rv_core_pkg::LUI) ? rv_core_pkg::OP1_ZERO
                                                          : rv_core_pkg::OP1_PC;
                op2_sel = rv_core_pkg::OP2_IMU;
                wb_sel = rv_core_pkg::WB_ALU;
                illegal = 1'b0;
            end
            rv_core_pkg::SYSTEM: begin
                if (inst == 32'h0000_0073) begin  // csr ops fall through as illegal
                    ecall = 1'b1;
                    illegal = 1'b0;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    assign uses_rs1 = (op1_sel == rv_core_pkg::OP1_RS1);
    // stores are the only users of the s immediate
    assign uses_rs2 = (op2_sel == rv_core_pkg::OP2_RS2) || (op2_sel == rv_core_pkg::OP2_IMS);

endmodule

// File: source/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NONE,  // zero after reset
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,  // add then clear bit 0
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } alu_fun_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_IMI,
        OP2_IMS,
        OP2_IMJ,
        OP2_IMU,
        OP2_ZERO
    } op2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_PC4,
        WB_MEM  // never written without data memory
    } wb_sel_e;

endpackage
